// ==== flist.f ====
source/exe_pkg.sv
source/alu.sv
source/divider.sv
source/exe_stage.sv
source/data_ram.sv
source/mem_stage.sv
source/exe_top.sv
sim/exe_tb.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f flist.f --top-module exe_tb -o exe_sim

sim_out=$(./obj_dir/exe_sim)
echo "$sim_out"
echo "$sim_out" | grep -qx "RESULT: PASS"

// ==== sim/exe_tb.sv ====
`timescale 1ns/1ps

module exe_tb;
    import exe_pkg::*;

    localparam int num_instr  = 300;
    localparam int max_cycles = 60 * num_instr + 100;

    typedef struct packed {
        logic                      check_result;
        logic                      gr_we;
        logic [reg_addr_width-1:0] dest;
        logic [data_width-1:0]     result;
        logic [data_width-1:0]     pc;
    } wb_rec_t;

    logic                      clk;
    logic                      reset;
    logic                      ds_to_es_valid;
    logic                      es_allowin;
    logic [alu_op_width-1:0]   alu_op;
    mdu_op_t                   mdu_op;
    logic                      load_op;
    logic                      src1_is_pc;
    logic                      src2_is_imm;
    logic                      gr_we;
    logic                      mem_we;
    logic [reg_addr_width-1:0] dest;
    logic [data_width-1:0]     imm;
    logic [data_width-1:0]     rj_value;
    logic [data_width-1:0]     rkd_value;
    logic [data_width-1:0]     pc;
    logic                      ws_allowin;
    logic                      ms_to_ws_valid;
    logic                      ws_gr_we;
    logic [reg_addr_width-1:0] ws_dest;
    logic [data_width-1:0]     ws_result;
    logic [data_width-1:0]     ws_pc;

    wb_rec_t               exp_q[$];
    logic [data_width-1:0] shadow_mem [256];
    logic                  shadow_valid [256];
    logic [31:0]           lcg_state;
    int                    op_idx;
    int                    issued = 0;
    int                    checks = 0;
    int                    value_errors = 0;
    int                    other_errors = 0;
    int                    cycle_count = 0;
    logic                  have_instr;
    wb_rec_t               new_rec;

    exe_top #(
        .ram_addr_width (8)
    ) exe_top_i (
        .clk            (clk),
        .reset          (reset),
        .ds_to_es_valid (ds_to_es_valid),
        .es_allowin     (es_allowin),
        .alu_op         (alu_op),
        .mdu_op         (mdu_op),
        .load_op        (load_op),
        .src1_is_pc     (src1_is_pc),
        .src2_is_imm    (src2_is_imm),
        .gr_we          (gr_we),
        .mem_we         (mem_we),
        .dest           (dest),
        .imm            (imm),
        .rj_value       (rj_value),
        .rkd_value      (rkd_value),
        .pc             (pc),
        .ws_allowin     (ws_allowin),
        .ms_to_ws_valid (ms_to_ws_valid),
        .ws_gr_we       (ws_gr_we),
        .ws_dest        (ws_dest),
        .ws_result      (ws_result),
        .ws_pc          (ws_pc)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // two lcg steps, upper halves joined
    function automatic logic [31:0] next_rand();
        logic [15:0] hi;
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        hi = lcg_state[31:16];
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return {hi, lcg_state[31:16]};
    endfunction

    function automatic logic [31:0] ref_alu(int idx, logic [31:0] a, logic [31:0] b);
        case (idx)
            alu_add:  return a + b;
            alu_sub:  return a - b;
            alu_slt:  return {31'b0, $signed(a) < $signed(b)};
            alu_sltu: return {31'b0, a < b};
            alu_and:  return a & b;
            alu_nor:  return ~(a | b);
            alu_or:   return a | b;
            alu_xor:  return a ^ b;
            alu_sll:  return a << b[4:0];
            alu_srl:  return a >> b[4:0];
            alu_sra:  return $signed(a) >>> b[4:0];
            default:  return b;
        endcase
    endfunction

    // 64-bit arithmetic, so truncation and signs follow the language
    function automatic logic [31:0] ref_mdu(mdu_op_t op, logic [31:0] a, logic [31:0] b);
        logic signed [63:0] sa;
        logic signed [63:0] sb;
        logic signed [63:0] sr;
        logic [63:0]        ua;
        logic [63:0]        ub;
        logic [63:0]        ur;
        sa = {{32{a[31]}}, a};
        sb = {{32{b[31]}}, b};
        ua = {32'b0, a};
        ub = {32'b0, b};
        case (op)
            mdu_mul_w:   sr = sa * sb;
            mdu_mulh_w:  sr = (sa * sb) >>> 32;
            mdu_div_w:   sr = sa / sb;
            mdu_mod_w:   sr = sa % sb;
            default:     sr = '0;
        endcase
        case (op)
            mdu_mulh_wu: ur = (ua * ub) >> 32;
            mdu_div_wu:  ur = ua / ub;
            mdu_mod_wu:  ur = ua % ub;
            default:     ur = sr;
        endcase
        return ur[31:0];
    endfunction

    function automatic wb_rec_t expect_record();
        wb_rec_t     rec;
        logic [31:0] src1;
        logic [31:0] src2;
        src1 = src1_is_pc ? pc : rj_value;
        src2 = src2_is_imm ? imm : rkd_value;
        rec.check_result = 1'b1;
        rec.gr_we = gr_we;
        rec.dest = dest;
        rec.pc = pc;
        if (mdu_op != mdu_none) begin
            rec.result = ref_mdu(mdu_op, rj_value, rkd_value);
        end else begin
            rec.result = ref_alu(op_idx, src1, src2);
        end
        // loads from words never stored are skipped
        if (load_op) begin
            rec.check_result = shadow_valid[rec.result[7:0]];
            rec.result = shadow_mem[rec.result[7:0]];
        end
        return rec;
    endfunction

    task automatic build_instr();
        logic [31:0] r;
        int          kind;
        r = next_rand();
        kind = int'(r % 8);
        mdu_op = mdu_none;
        load_op = 1'b0;
        mem_we = 1'b0;
        gr_we = 1'b1;
        src1_is_pc = 1'b0;
        src2_is_imm = 1'b0;
        op_idx = alu_add;
        rj_value = next_rand();
        rkd_value = next_rand();
        imm = next_rand();
        dest = r[12:8];
        pc = 32'h1c00_0000 + 32'(issued) * 32'd4;
        case (kind)
            4: mdu_op = mdu_op_t'(3'(32'd1 + r[23:16] % 3));
            5: begin
                mdu_op = mdu_op_t'(3'(32'd4 + r[23:16] % 4));
                // small signed divisors now and then
                if (r[24]) rkd_value = {{28{r[29]}}, r[29:26]};
                if (rkd_value == 32'd0) rkd_value = 32'd1;
            end
            6, 7: begin
                // word addresses 0 to 30 so loads often hit stores
                rj_value = {28'b0, r[19:16]};
                imm = {28'b0, r[23:20]};
                src2_is_imm = 1'b1;
                mem_we = (kind == 6);
                load_op = (kind == 7);
                gr_we = (kind == 7);
            end
            default: begin
                op_idx = int'(r[23:16] % 12);
                src1_is_pc = r[24];
                src2_is_imm = r[25];
            end
        endcase
        alu_op = 12'b1 << op_idx;
    endtask

    task automatic check_value(string name, logic [31:0] expected, logic [31:0] actual);
        checks++;
        assert (actual == expected) else begin
            $display("** Error at %0d ns: %s expected %h, got %h", $time, name, expected,
                     actual);
            value_errors++;
        end
    endtask

    // records leave on the edge after this negedge
    always @(negedge clk) begin
        wb_rec_t rec;
        #1;
        if (!reset && ms_to_ws_valid && ws_allowin) begin
            if (exp_q.size() == 0) begin
                $display("record for pc %h came out with nothing left to expect", ws_pc);
                other_errors++;
            end else begin
                rec = exp_q.pop_front();
                check_value("ws_pc", rec.pc, ws_pc);
                check_value("ws_gr_we", 32'(rec.gr_we), 32'(ws_gr_we));
                check_value("ws_dest", 32'(rec.dest), 32'(ws_dest));
                if (rec.check_result) check_value("ws_result", rec.result, ws_result);
            end
        end
    end

    initial begin
        while (cycle_count < max_cycles) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("run stopped after %0d cycles with %0d records outstanding",
                 cycle_count, exp_q.size());
        $display("RESULT: FAIL");
        $finish;
    end

    initial begin
        lcg_state = 32'd57;
        reset = 1'b1;
        ds_to_es_valid = 1'b0;
        alu_op = '0;
        mdu_op = mdu_none;
        load_op = 1'b0;
        src1_is_pc = 1'b0;
        src2_is_imm = 1'b0;
        gr_we = 1'b0;
        mem_we = 1'b0;
        dest = '0;
        imm = '0;
        rj_value = '0;
        rkd_value = '0;
        pc = '0;
        ws_allowin = 1'b1;
        have_instr = 1'b0;
        for (int i = 0; i < 256; i++) shadow_valid[i] = 1'b0;
        repeat (5) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        // idle pipeline before any input
        repeat (4) begin
            @(negedge clk);
            #1;
            assert (!ms_to_ws_valid && !exe_top_i.es_to_ms_valid
                    && !exe_top_i.exe_stage_i.div_start && !exe_top_i.exe_stage_i.div_done
                    && exe_top_i.data_sram_we == 4'h0) else begin
                $display("pipeline not idle after reset at %0d ns", $time);
                other_errors++;
            end
        end

        while (issued < num_instr) begin
            @(negedge clk);
            ws_allowin = (next_rand() % 4) != 0;
            if (!have_instr) begin
                if (next_rand() % 5 == 0) begin
                    ds_to_es_valid = 1'b0;
                end else begin
                    build_instr();
                    have_instr = 1'b1;
                    ds_to_es_valid = 1'b1;
                end
            end
            #1;
            if (ds_to_es_valid && es_allowin) begin
                new_rec = expect_record();
                exp_q.push_back(new_rec);
                if (mem_we) begin
                    shadow_mem[new_rec.result[7:0]] = rkd_value;
                    shadow_valid[new_rec.result[7:0]] = 1'b1;
                end
                issued++;
                have_instr = 1'b0;
            end
        end

        @(negedge clk);
        ds_to_es_valid = 1'b0;
        while (exp_q.size() != 0) begin
            @(negedge clk);
            ws_allowin = (next_rand() % 4) != 0;
        end
        ws_allowin = 1'b1;
        repeat (5) @(negedge clk);

        if (exp_q.size() != 0) begin
            $display("%0d expected records never came out", exp_q.size());
            other_errors++;
        end
        $display("issued %0d, checks %0d, value errors %0d, other errors %0d",
                 issued, checks, value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

// ==== source/alu.sv ====
`timescale 1ns/1ps

module alu (
    input  logic [exe_pkg::alu_op_width-1:0] alu_op,
    input  logic [exe_pkg::data_width-1:0]   alu_src1,
    input  logic [exe_pkg::data_width-1:0]   alu_src2,
    output logic [exe_pkg::data_width-1:0]   alu_result
);
    import exe_pkg::*;

    logic [data_width-1:0] add_sub_result;
    logic [data_width-1:0] slt_result;
    logic [data_width-1:0] sltu_result;
    logic [data_width-1:0] sra_result;
    logic [4:0]            shamt;

    // sub shares the adder result
    assign add_sub_result = alu_op[alu_sub] ? alu_src1 - alu_src2 : alu_src1 + alu_src2;
    assign slt_result     = {{(data_width-1){1'b0}}, $signed(alu_src1) < $signed(alu_src2)};
    assign sltu_result    = {{(data_width-1){1'b0}}, alu_src1 < alu_src2};
    assign shamt          = alu_src2[4:0];
    assign sra_result     = $signed(alu_src1) >>> shamt;

    always_comb begin
        alu_result = '0;
        alu_result |= {data_width{alu_op[alu_add] | alu_op[alu_sub]}} & add_sub_result;
        alu_result |= {data_width{alu_op[alu_slt]}}   & slt_result;
        alu_result |= {data_width{alu_op[alu_sltu]}}  & sltu_result;
        alu_result |= {data_width{alu_op[alu_and]}}   & (alu_src1 & alu_src2);
        alu_result |= {data_width{alu_op[alu_nor]}}   & ~(alu_src1 | alu_src2);
        alu_result |= {data_width{alu_op[alu_or]}}    & (alu_src1 | alu_src2);
        alu_result |= {data_width{alu_op[alu_xor]}}   & (alu_src1 ^ alu_src2);
        alu_result |= {data_width{alu_op[alu_sll]}}   & (alu_src1 << shamt);
        alu_result |= {data_width{alu_op[alu_srl]}}   & (alu_src1 >> shamt);
        alu_result |= {data_width{alu_op[alu_sra]}}   & sra_result;
        // src2 already holds the shifted immediate
        alu_result |= {data_width{alu_op[alu_lui12]}} & alu_src2;
    end

endmodule

// ==== source/data_ram.sv ====
`timescale 1ns/1ps

module data_ram #(
    parameter int ram_addr_width = 8
) (
    input  logic        clk,
    input  logic        data_sram_en,
    input  logic [3:0]  data_sram_we,
    input  logic [31:0] data_sram_addr,
    input  logic [31:0] data_sram_wdata,
    output logic [31:0] data_sram_rdata
);

    logic [31:0]               mem [2**ram_addr_width];
    logic [ram_addr_width-1:0] word_addr;

    // address is already a word index
    assign word_addr = data_sram_addr[ram_addr_width-1:0];

    always_ff @(posedge clk) begin
        if (data_sram_en) begin
            for (int i = 0; i < 4; i++) begin
                if (data_sram_we[i]) begin
                    mem[word_addr][8*i +: 8] <= data_sram_wdata[8*i +: 8];
                end
            end
            data_sram_rdata <= mem[word_addr];
        end
    end

endmodule

// ==== source/divider.sv ====
`timescale 1ns/1ps

module divider (
    input  logic                           clk,
    input  logic                           reset,
    input  logic                           div_start,
    input  logic                           div_signed,
    input  logic [exe_pkg::data_width-1:0] dividend,
    input  logic [exe_pkg::data_width-1:0] divisor,
    output logic [exe_pkg::data_width-1:0] quotient,
    output logic [exe_pkg::data_width-1:0] remainder,
    output logic                           done
);
    import exe_pkg::*;

    localparam int cnt_width = $clog2(data_width);
    localparam logic [cnt_width-1:0] last_step = cnt_width'(data_width - 1);

    logic                  busy;
    logic [cnt_width-1:0]  step_cnt;
    logic [data_width-1:0] quot_mag;
    logic [data_width-1:0] rem_mag;
    logic [data_width-1:0] dsor_mag;
    logic                  quot_neg;
    logic                  rem_neg;
    logic [data_width-1:0] dividend_abs;
    logic [data_width-1:0] divisor_abs;
    logic [data_width:0]   trial;

    assign dividend_abs = (div_signed && dividend[data_width-1]) ? -dividend : dividend;
    assign divisor_abs  = (div_signed && divisor[data_width-1])  ? -divisor  : divisor;

    // shifted partial remainder minus divisor, borrow in the top bit
    assign trial = {rem_mag, quot_mag[data_width-1]} - {1'b0, dsor_mag};

    always_ff @(posedge clk) begin
        if (reset) begin
            busy     <= 1'b0;
            step_cnt <= '0;
            done     <= 1'b0;
        end else if (div_start) begin
            busy     <= 1'b1;
            step_cnt <= '0;
            done     <= 1'b0;
        end else if (busy) begin
            step_cnt <= step_cnt + 1'b1;
            if (step_cnt == last_step) begin
                busy <= 1'b0;
                done <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (div_start) begin
            quot_mag <= dividend_abs;
            rem_mag  <= '0;
            dsor_mag <= divisor_abs;
            quot_neg <= div_signed && (dividend[data_width-1] ^ divisor[data_width-1]);
            rem_neg  <= div_signed && dividend[data_width-1];
        end else if (busy) begin
            if (!trial[data_width]) begin
                rem_mag  <= trial[data_width-1:0];
                quot_mag <= {quot_mag[data_width-2:0], 1'b1};
            end else begin
                rem_mag  <= {rem_mag[data_width-2:0], quot_mag[data_width-1]};
                quot_mag <= {quot_mag[data_width-2:0], 1'b0};
            end
        end
    end

    // sign fix on the held magnitudes
    assign quotient  = quot_neg ? -quot_mag : quot_mag;
    assign remainder = rem_neg  ? -rem_mag  : rem_mag;

endmodule

// ==== source/exe_pkg.sv ====
package exe_pkg;

    localparam int data_width     = 32;
    localparam int reg_addr_width = 5;
    localparam int alu_op_width   = 12;

    // bit positions in the one-hot alu op
    localparam int alu_add   = 0;
    localparam int alu_sub   = 1;
    localparam int alu_slt   = 2;
    localparam int alu_sltu  = 3;
    localparam int alu_and   = 4;
    localparam int alu_nor   = 5;
    localparam int alu_or    = 6;
    localparam int alu_xor   = 7;
    localparam int alu_sll   = 8;
    localparam int alu_srl   = 9;
    localparam int alu_sra   = 10;
    localparam int alu_lui12 = 11;

    // multiply/divide path select
    typedef enum logic [2:0] {
        mdu_none    = 3'd0,
        mdu_mul_w   = 3'd1,
        mdu_mulh_w  = 3'd2,
        mdu_mulh_wu = 3'd3,
        mdu_div_w   = 3'd4,
        mdu_mod_w   = 3'd5,
        mdu_div_wu  = 3'd6,
        mdu_mod_wu  = 3'd7
    } mdu_op_t;

endpackage

// ==== source/exe_stage.sv ====
`timescale 1ns/1ps

module exe_stage (
    input  logic                               clk,
    input  logic                               reset,
    input  logic                               ds_to_es_valid,
    output logic                               es_allowin,
    input  logic [exe_pkg::alu_op_width-1:0]   alu_op,
    input  exe_pkg::mdu_op_t                   mdu_op,
    input  logic                               load_op,
    input  logic                               src1_is_pc,
    input  logic                               src2_is_imm,
    input  logic                               gr_we,
    input  logic                               mem_we,
    input  logic [exe_pkg::reg_addr_width-1:0] dest,
    input  logic [exe_pkg::data_width-1:0]     imm,
    input  logic [exe_pkg::data_width-1:0]     rj_value,
    input  logic [exe_pkg::data_width-1:0]     rkd_value,
    input  logic [exe_pkg::data_width-1:0]     pc,
    input  logic                               ms_allowin,
    output logic                               es_to_ms_valid,
    output logic                               es_res_from_mem,
    output logic                               es_gr_we,
    output logic [exe_pkg::reg_addr_width-1:0] es_dest,
    output logic [exe_pkg::data_width-1:0]     es_result,
    output logic [exe_pkg::data_width-1:0]     es_pc,
    output logic                               data_sram_en,
    output logic [3:0]                         data_sram_we,
    output logic [exe_pkg::data_width-1:0]     data_sram_addr,
    output logic [exe_pkg::data_width-1:0]     data_sram_wdata
);
    import exe_pkg::*;

    logic                      es_valid;
    logic                      es_ready_go;
    logic [alu_op_width-1:0]   es_alu_op;
    mdu_op_t                   es_mdu_op;
    logic                      es_src1_is_pc;
    logic                      es_src2_is_imm;
    logic                      es_mem_we;
    logic [data_width-1:0]     es_imm;
    logic [data_width-1:0]     es_rj_value;
    logic [data_width-1:0]     es_rkd_value;
    logic [data_width-1:0]     es_alu_src1;
    logic [data_width-1:0]     es_alu_src2;
    logic [data_width-1:0]     es_alu_result;
    logic [2*data_width-1:0]   prod_signed;
    logic [2*data_width-1:0]   prod_unsigned;
    logic                      es_is_div;
    logic                      div_start;
    logic                      div_signed;
    logic                      div_started;
    logic                      div_done;
    logic [data_width-1:0]     div_quotient;
    logic [data_width-1:0]     div_remainder;
    logic                      es_transfer;

    always_ff @(posedge clk) begin
        if (reset) begin
            es_valid <= 1'b0;
        end else if (es_allowin) begin
            es_valid <= ds_to_es_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (ds_to_es_valid && es_allowin) begin
            es_alu_op       <= alu_op;
            es_mdu_op       <= mdu_op;
            es_res_from_mem <= load_op;
            es_src1_is_pc   <= src1_is_pc;
            es_src2_is_imm  <= src2_is_imm;
            es_gr_we        <= gr_we;
            es_mem_we       <= mem_we;
            es_dest         <= dest;
            es_imm          <= imm;
            es_rj_value     <= rj_value;
            es_rkd_value    <= rkd_value;
            es_pc           <= pc;
        end
    end

    assign es_alu_src1 = es_src1_is_pc  ? es_pc  : es_rj_value;
    assign es_alu_src2 = es_src2_is_imm ? es_imm : es_rkd_value;

    alu alu_i (
        .alu_op     (es_alu_op),
        .alu_src1   (es_alu_src1),
        .alu_src2   (es_alu_src2),
        .alu_result (es_alu_result)
    );

    // sign-extended operands give the full signed product
    assign prod_signed   = {{data_width{es_rj_value[data_width-1]}}, es_rj_value}
                           * {{data_width{es_rkd_value[data_width-1]}}, es_rkd_value};
    assign prod_unsigned = {{data_width{1'b0}}, es_rj_value}
                           * {{data_width{1'b0}}, es_rkd_value};

    assign es_is_div  = es_mdu_op inside {mdu_div_w, mdu_mod_w, mdu_div_wu, mdu_mod_wu};
    assign div_signed = (es_mdu_op == mdu_div_w) || (es_mdu_op == mdu_mod_w);
    // one start per divide instruction
    assign div_start  = es_valid && es_is_div && !div_started;

    always_ff @(posedge clk) begin
        if (reset) begin
            div_started <= 1'b0;
        end else if (div_start) begin
            div_started <= 1'b1;
        end else if (es_transfer) begin
            div_started <= 1'b0;
        end
    end

    divider divider_i (
        .clk        (clk),
        .reset      (reset),
        .div_start  (div_start),
        .div_signed (div_signed),
        .dividend   (es_rj_value),
        .divisor    (es_rkd_value),
        .quotient   (div_quotient),
        .remainder  (div_remainder),
        .done       (div_done)
    );

    always_comb begin
        case (es_mdu_op)
            mdu_mul_w:             es_result = prod_signed[data_width-1:0];
            mdu_mulh_w:            es_result = prod_signed[2*data_width-1:data_width];
            mdu_mulh_wu:           es_result = prod_unsigned[2*data_width-1:data_width];
            mdu_div_w, mdu_div_wu: es_result = div_quotient;
            mdu_mod_w, mdu_mod_wu: es_result = div_remainder;
            default:               es_result = es_alu_result;
        endcase
    end

    assign es_ready_go    = es_is_div ? (div_started && div_done) : 1'b1;
    assign es_allowin     = !es_valid || (es_ready_go && ms_allowin);
    assign es_to_ms_valid = es_valid && es_ready_go;
    assign es_transfer    = es_to_ms_valid && ms_allowin;

    // ram access only on the edge the item moves to memory
    assign data_sram_en    = es_transfer;
    assign data_sram_we    = (es_transfer && es_mem_we) ? 4'hf : 4'h0;
    assign data_sram_addr  = es_alu_result;
    assign data_sram_wdata = es_rkd_value;

endmodule

// ==== source/exe_top.sv ====
`timescale 1ns/1ps

module exe_top #(
    parameter int ram_addr_width = 8
) (
    input  logic                               clk,
    input  logic                               reset,
    input  logic                               ds_to_es_valid,
    output logic                               es_allowin,
    input  logic [exe_pkg::alu_op_width-1:0]   alu_op,
    input  exe_pkg::mdu_op_t                   mdu_op,
    input  logic                               load_op,
    input  logic                               src1_is_pc,
    input  logic                               src2_is_imm,
    input  logic                               gr_we,
    input  logic                               mem_we,
    input  logic [exe_pkg::reg_addr_width-1:0] dest,
    input  logic [exe_pkg::data_width-1:0]     imm,
    input  logic [exe_pkg::data_width-1:0]     rj_value,
    input  logic [exe_pkg::data_width-1:0]     rkd_value,
    input  logic [exe_pkg::data_width-1:0]     pc,
    input  logic                               ws_allowin,
    output logic                               ms_to_ws_valid,
    output logic                               ws_gr_we,
    output logic [exe_pkg::reg_addr_width-1:0] ws_dest,
    output logic [exe_pkg::data_width-1:0]     ws_result,
    output logic [exe_pkg::data_width-1:0]     ws_pc
);
    import exe_pkg::*;

    logic                      ms_allowin;
    logic                      es_to_ms_valid;
    logic                      es_res_from_mem;
    logic                      es_gr_we;
    logic [reg_addr_width-1:0] es_dest;
    logic [data_width-1:0]     es_result;
    logic [data_width-1:0]     es_pc;
    logic                      data_sram_en;
    logic [3:0]                data_sram_we;
    logic [data_width-1:0]     data_sram_addr;
    logic [data_width-1:0]     data_sram_wdata;
    logic [data_width-1:0]     data_sram_rdata;

    exe_stage exe_stage_i (
        .clk             (clk),
        .reset           (reset),
        .ds_to_es_valid  (ds_to_es_valid),
        .es_allowin      (es_allowin),
        .alu_op          (alu_op),
        .mdu_op          (mdu_op),
        .load_op         (load_op),
        .src1_is_pc      (src1_is_pc),
        .src2_is_imm     (src2_is_imm),
        .gr_we           (gr_we),
        .mem_we          (mem_we),
        .dest            (dest),
        .imm             (imm),
        .rj_value        (rj_value),
        .rkd_value       (rkd_value),
        .pc              (pc),
        .ms_allowin      (ms_allowin),
        .es_to_ms_valid  (es_to_ms_valid),
        .es_res_from_mem (es_res_from_mem),
        .es_gr_we        (es_gr_we),
        .es_dest         (es_dest),
        .es_result       (es_result),
        .es_pc           (es_pc),
        .data_sram_en    (data_sram_en),
        .data_sram_we    (data_sram_we),
        .data_sram_addr  (data_sram_addr),
        .data_sram_wdata (data_sram_wdata)
    );

    data_ram #(
        .ram_addr_width (ram_addr_width)
    ) data_ram_i (
        .clk             (clk),
        .data_sram_en    (data_sram_en),
        .data_sram_we    (data_sram_we),
        .data_sram_addr  (data_sram_addr),
        .data_sram_wdata (data_sram_wdata),
        .data_sram_rdata (data_sram_rdata)
    );

    mem_stage mem_stage_i (
        .clk             (clk),
        .reset           (reset),
        .es_to_ms_valid  (es_to_ms_valid),
        .ms_allowin      (ms_allowin),
        .es_res_from_mem (es_res_from_mem),
        .es_gr_we        (es_gr_we),
        .es_dest         (es_dest),
        .es_result       (es_result),
        .es_pc           (es_pc),
        .data_sram_rdata (data_sram_rdata),
        .ws_allowin      (ws_allowin),
        .ms_to_ws_valid  (ms_to_ws_valid),
        .ws_gr_we        (ws_gr_we),
        .ws_dest         (ws_dest),
        .ws_result       (ws_result),
        .ws_pc           (ws_pc)
    );

endmodule

// ==== source/mem_stage.sv ====
`timescale 1ns/1ps

module mem_stage (
    input  logic                               clk,
    input  logic                               reset,
    input  logic                               es_to_ms_valid,
    output logic                               ms_allowin,
    input  logic                               es_res_from_mem,
    input  logic                               es_gr_we,
    input  logic [exe_pkg::reg_addr_width-1:0] es_dest,
    input  logic [exe_pkg::data_width-1:0]     es_result,
    input  logic [exe_pkg::data_width-1:0]     es_pc,
    input  logic [exe_pkg::data_width-1:0]     data_sram_rdata,
    input  logic                               ws_allowin,
    output logic                               ms_to_ws_valid,
    output logic                               ws_gr_we,
    output logic [exe_pkg::reg_addr_width-1:0] ws_dest,
    output logic [exe_pkg::data_width-1:0]     ws_result,
    output logic [exe_pkg::data_width-1:0]     ws_pc
);
    import exe_pkg::*;

    logic                  ms_valid;
    logic                  ms_res_from_mem;
    logic [data_width-1:0] ms_result;

    always_ff @(posedge clk) begin
        if (reset) begin
            ms_valid <= 1'b0;
        end else if (ms_allowin) begin
            ms_valid <= es_to_ms_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (es_to_ms_valid && ms_allowin) begin
            ms_res_from_mem <= es_res_from_mem;
            ws_gr_we        <= es_gr_we;
            ws_dest         <= es_dest;
            ms_result       <= es_result;
            ws_pc           <= es_pc;
        end
    end

    // memory stage always completes in one cycle
    assign ms_allowin     = !ms_valid || ws_allowin;
    assign ms_to_ws_valid = ms_valid;
    assign ws_result      = ms_res_from_mem ? data_sram_rdata : ms_result;

endmodule
